// ==== common/vicPkg.sv ====
package vicPkg;

  // ------------------------------
  // chip and register encodings
  // ------------------------------

  // selects the frame limits
  typedef enum logic [1:0] {
    CHIP6567R8,
    CHIP6567R56A,
    CHIP6569,
    CHIPUNUSED
  } chipType;

  // register offsets still decoded by the cpu interface
  typedef enum logic [5:0] {
    RegControl1        = 6'h11,
    RegRasterLine      = 6'h12,
    RegControl2        = 6'h16,
    RegIrqFlags        = 6'h19,
    RegIrqEnable       = 6'h1A,
    RegBorderColor     = 6'h20,
    RegBackgroundColor = 6'h21
  } regAddr;

  // widths
  localparam int RasterXWidth    = 10;
  localparam int RasterLineWidth = 9;
  localparam int ColorWidth      = 4;
  localparam int BusWidth        = 12;

  // clock ratios
  localparam int DotsPerPhiCycle = 8;
  localparam int TicksPerDot     = 4;

  // top and bottom border lines for 25 and 24 rows
  localparam int RowOpen25  = 51;
  localparam int RowOpen24  = 55;
  localparam int RowClose25 = 251;
  localparam int RowClose24 = 247;

  // left and right border columns for 40 and 38 columns
  localparam int ColOpen40  = 24;
  localparam int ColOpen38  = 31;
  localparam int ColClose40 = 344;
  localparam int ColClose38 = 335;

  // ------------------------------
  // per chip frame limits, indexed by chipType
  // ------------------------------
  localparam logic [RasterXWidth-1:0] rasterXMax [4] = '{10'd519, 10'd511, 10'd503, 10'd503};
  localparam logic [RasterLineWidth-1:0] rasterYMax [4] = '{9'd262, 9'd261, 9'd311, 9'd311};
  localparam logic [RasterXWidth-1:0] hBlankStart [4] = '{10'd406, 10'd406, 10'd408, 10'd408};
  localparam logic [RasterXWidth-1:0] hVisibleStart [4] = '{10'd494, 10'd494, 10'd492, 10'd492};
  localparam logic [RasterLineWidth-1:0] vBlankStart [4] = '{9'd11, 9'd11, 9'd301, 9'd301};
  localparam logic [RasterLineWidth-1:0] vBlankEnd [4] = '{9'd19, 9'd19, 9'd309, 9'd309};

endpackage

// ==== list.f ====
common/vicPkg.sv
raster/rasterTiming.sv
raster/rasterIrq.sv
src/vicRegisters.sv
src/borderUnit.sv
src/colorOutput.sv
src/vicVideo.sv
verif/vicVideoTb.sv

// ==== raster/rasterIrq.sv ====
module rasterIrq
  import vicPkg::*;
(
  input  logic                       clk_dot4x,
  input  logic                       rst,
  input  logic                       dotStrobe,
  input  logic [RasterXWidth-1:0]    rasterX,
  input  logic [RasterLineWidth-1:0] rasterLine,
  input  logic [RasterLineWidth-1:0] rasterCmp,
  input  logic                       rasterIrqEnable,
  input  logic                       rasterIrqClear,
  output logic                       rasterIrqFlag,
  output logic                       irq
);

  // compare hits once per line at the first dot
  logic match;

  assign match = dotStrobe && (rasterX == '0) && (rasterLine == rasterCmp);

  // latch is kept even while the enable is off
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      rasterIrqFlag <= 1'b0;
    end else if (match) begin
      // a fresh match beats a clear on the same clock
      rasterIrqFlag <= 1'b1;
    end else if (rasterIrqClear) begin
      rasterIrqFlag <= 1'b0;
    end
  end

  // enabling with a pending flag raises irq right away
  assign irq = rasterIrqFlag & rasterIrqEnable;

endmodule

// ==== raster/rasterTiming.sv ====
module rasterTiming
  import vicPkg::*;
(
  input  logic                       clk_dot4x,
  input  logic                       rst,
  input  chipType                    chip,
  output logic                       dotStrobe,
  output logic                       phiEnd,
  output logic                       clk_phi,
  output logic [RasterXWidth-1:0]    rasterX,
  output logic [RasterLineWidth-1:0] rasterLine
);

  // four ticks of clk_dot4x make one dot
  logic [1:0] tick;
  // eight dots make one phi cycle
  logic [2:0] dotInCycle;
  // limits of the selected chip
  logic [RasterXWidth-1:0] xMax;
  logic [RasterLineWidth-1:0] yMax;

  assign xMax = rasterXMax[chip];
  assign yMax = rasterYMax[chip];

  // ------------------------------
  // dot and phi phases
  // ------------------------------
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      tick <= 2'd0;
    end else begin
      tick <= tick + 2'd1;
    end
  end

  // last tick of each dot
  assign dotStrobe = (tick == 2'(TicksPerDot - 1));

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      dotInCycle <= 3'd0;
    end else if (dotStrobe) begin
      dotInCycle <= dotInCycle + 3'd1;
    end
  end

  // phi low for the first four dots, high for the rest
  assign clk_phi = (dotInCycle >= 3'(DotsPerPhiCycle / 2));
  // final clock of the phi high half
  assign phiEnd = dotStrobe && (dotInCycle == 3'(DotsPerPhiCycle - 1));

  // ------------------------------
  // raster position
  // ------------------------------
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      rasterX <= '0;
      rasterLine <= '0;
    end else if (dotStrobe) begin
      if (rasterX >= xMax) begin
        // end of line
        rasterX <= '0;
        if (rasterLine >= yMax) begin
          rasterLine <= '0;
        end else begin
          rasterLine <= rasterLine + 1'b1;
        end
      end else begin
        rasterX <= rasterX + 1'b1;
      end
    end
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the vicVideo testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module vicVideoTb -Mdir obj_dir -o vicVideoSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/vicVideoSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

# the testbench prints the fail message on any error or timeout
if grep -q "Some tests failed" sim.log; then
  exit 1
fi
exit 0

// ==== src/borderUnit.sv ====
module borderUnit
  import vicPkg::*;
(
  input  logic                       clk_dot4x,
  input  logic                       rst,
  input  logic                       dotStrobe,
  input  logic [RasterXWidth-1:0]    rasterX,
  input  logic [RasterLineWidth-1:0] rasterLine,
  input  logic                       rsel,
  input  logic                       den,
  input  logic                       csel,
  output logic                       inBorder
);

  // top/bottom and left/right border flags
  logic vBorder;
  logic hBorder;
  logic newVBorder;
  logic [RasterLineWidth-1:0] rowOpen;
  logic [RasterLineWidth-1:0] rowClose;
  logic [RasterXWidth-1:0] colOpen;
  logic [RasterXWidth-1:0] colClose;

  // rsel picks 25 or 24 rows, csel picks 40 or 38 columns
  assign rowOpen = rsel ? RasterLineWidth'(RowOpen25) : RasterLineWidth'(RowOpen24);
  assign rowClose = rsel ? RasterLineWidth'(RowClose25) : RasterLineWidth'(RowClose24);
  assign colOpen = csel ? RasterXWidth'(ColOpen40) : RasterXWidth'(ColOpen38);
  assign colClose = csel ? RasterXWidth'(ColClose40) : RasterXWidth'(ColClose38);

  // ------------------------------
  // vertical state for this line
  // ------------------------------
  always_comb begin
    newVBorder = vBorder;
    // display only opens when den is set on the open line
    if (rasterLine == rowOpen && den) begin
      newVBorder = 1'b0;
    end
    if (rasterLine == rowClose) begin
      newVBorder = 1'b1;
    end
  end

  // flags only move on dot boundaries
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      vBorder <= 1'b1;
      hBorder <= 1'b1;
    end else if (dotStrobe) begin
      if (rasterX == colOpen) begin
        vBorder <= newVBorder;
        hBorder <= newVBorder;
      end
      if (rasterX == colClose) begin
        hBorder <= 1'b1;
      end
    end
  end

  assign inBorder = vBorder | hBorder;

endmodule

// ==== src/colorOutput.sv ====
module colorOutput
  import vicPkg::*;
(
  input  logic                       clk_dot4x,
  input  logic                       rst,
  input  chipType                    chip,
  input  logic [RasterXWidth-1:0]    rasterX,
  input  logic [RasterLineWidth-1:0] rasterLine,
  input  logic                       inBorder,
  input  logic [ColorWidth-1:0]      borderColor,
  input  logic [ColorWidth-1:0]      backgroundColor,
  output logic [ColorWidth-1:0]      colorIndex
);

  logic vBlank;
  logic hBlank;
  logic blank;

  // vertical blank covers both end lines
  assign vBlank = (rasterLine >= vBlankStart[chip]) && (rasterLine <= vBlankEnd[chip]);
  // horizontal blank stops just before the visible start
  assign hBlank = (rasterX >= hBlankStart[chip]) && (rasterX < hVisibleStart[chip]);
  assign blank = vBlank | hBlank;

  // ------------------------------
  // output colour register
  // ------------------------------
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      colorIndex <= '0;
    end else if (blank) begin
      // black while blanked
      colorIndex <= '0;
    end else if (inBorder) begin
      colorIndex <= borderColor;
    end else begin
      colorIndex <= backgroundColor;
    end
  end

endmodule

// ==== src/vicRegisters.sv ====
module vicRegisters
  import vicPkg::*;
(
  input  logic                       clk_dot4x,
  input  logic                       rst,
  input  logic                       clk_phi,
  input  logic                       phiEnd,
  input  logic                       ce,
  input  logic                       rw,
  input  logic [BusWidth-1:0]        adi,
  input  logic [BusWidth-1:0]        dbi,
  output logic [BusWidth-1:0]        dbo,
  input  logic [RasterLineWidth-1:0] rasterLine,
  input  logic                       rasterIrqFlag,
  input  logic                       irq,
  output logic [RasterLineWidth-1:0] rasterCmp,
  output logic                       rasterIrqEnable,
  output logic                       rasterIrqClear,
  output logic                       rsel,
  output logic                       den,
  output logic                       csel,
  output logic [ColorWidth-1:0]      borderColor,
  output logic [ColorWidth-1:0]      backgroundColor
);

  regAddr addr;
  logic writeStrobe;
  logic readActive;
  logic [BusWidth-1:0] readValue;

  // only the low six address bits select a register
  assign addr = regAddr'(adi[5:0]);

  // cpu writes land at the end of phi high
  assign writeStrobe = phiEnd && !ce && !rw;
  // reads follow the bus for the whole phi high half
  assign readActive = clk_phi && !ce && rw;

  // ------------------------------
  // write capture
  // ------------------------------
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      rasterCmp <= '0;
      rasterIrqEnable <= 1'b0;
      rasterIrqClear <= 1'b0;
      rsel <= 1'b0;
      den <= 1'b1;
      csel <= 1'b0;
      borderColor <= '0;
      backgroundColor <= '0;
    end else begin
      // clear request lasts a single clock
      rasterIrqClear <= 1'b0;
      if (writeStrobe) begin
        case (addr)
          RegControl1: begin
            rsel <= dbi[3];
            den <= dbi[4];
            rasterCmp[RasterLineWidth-1] <= dbi[7];
          end
          RegRasterLine: rasterCmp[7:0] <= dbi[7:0];
          RegControl2: csel <= dbi[3];
          RegIrqFlags: rasterIrqClear <= dbi[0];
          RegIrqEnable: rasterIrqEnable <= dbi[0];
          RegBorderColor: borderColor <= dbi[ColorWidth-1:0];
          RegBackgroundColor: backgroundColor <= dbi[ColorWidth-1:0];
          default: ;
        endcase
      end
    end
  end

  // ------------------------------
  // read-back mux
  // ------------------------------
  always_comb begin
    // bits without a function read high
    readValue = '1;
    case (addr)
      RegControl1: begin
        readValue[3] = rsel;
        readValue[4] = den;
        readValue[7] = rasterLine[RasterLineWidth-1];
      end
      RegRasterLine: readValue[7:0] = rasterLine[7:0];
      RegControl2: readValue[3] = csel;
      RegIrqFlags: begin
        // bit 7 mirrors the active low irq pin
        readValue[7] = ~irq;
        readValue[0] = rasterIrqFlag;
      end
      RegIrqEnable: readValue[0] = rasterIrqEnable;
      RegBorderColor: readValue[ColorWidth-1:0] = borderColor;
      RegBackgroundColor: readValue[ColorWidth-1:0] = backgroundColor;
      default: ;
    endcase
  end

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      dbo <= '1;
    end else if (readActive) begin
      dbo <= readValue;
    end
  end

endmodule

// ==== src/vicVideo.sv ====
module vicVideo
  import vicPkg::*;
(
  input  logic                  clk_dot4x,
  input  logic                  rst,
  input  chipType               chip,
  input  logic                  ce,
  input  logic                  rw,
  input  logic [BusWidth-1:0]   adi,
  input  logic [BusWidth-1:0]   dbi,
  output logic [BusWidth-1:0]   dbo,
  output logic                  clk_phi,
  output logic                  irq,
  output logic [ColorWidth-1:0] colorIndex
);

  // timing to all blocks
  logic dotStrobe;
  logic phiEnd;
  logic [RasterXWidth-1:0] rasterX;
  logic [RasterLineWidth-1:0] rasterLine;

  // register levels
  logic [RasterLineWidth-1:0] rasterCmp;
  logic rasterIrqEnable;
  logic rasterIrqClear;
  logic rasterIrqFlag;
  logic rsel;
  logic den;
  logic csel;
  logic [ColorWidth-1:0] borderColor;
  logic [ColorWidth-1:0] backgroundColor;

  // border level into the colour stage
  logic inBorder;

  // ------------------------------
  // raster side
  // ------------------------------
  rasterTiming rasterTiming_i (
    .clk_dot4x(clk_dot4x), .rst(rst), .chip(chip), .dotStrobe(dotStrobe),
    .phiEnd(phiEnd), .clk_phi(clk_phi), .rasterX(rasterX), .rasterLine(rasterLine)
  );

  rasterIrq rasterIrq_i (
    .clk_dot4x(clk_dot4x), .rst(rst), .dotStrobe(dotStrobe), .rasterX(rasterX),
    .rasterLine(rasterLine), .rasterCmp(rasterCmp), .rasterIrqEnable(rasterIrqEnable),
    .rasterIrqClear(rasterIrqClear), .rasterIrqFlag(rasterIrqFlag), .irq(irq)
  );

  // cpu bus
  vicRegisters vicRegisters_i (
    .clk_dot4x(clk_dot4x), .rst(rst), .clk_phi(clk_phi), .phiEnd(phiEnd),
    .ce(ce), .rw(rw), .adi(adi), .dbi(dbi), .dbo(dbo), .rasterLine(rasterLine),
    .rasterIrqFlag(rasterIrqFlag), .irq(irq), .rasterCmp(rasterCmp),
    .rasterIrqEnable(rasterIrqEnable), .rasterIrqClear(rasterIrqClear),
    .rsel(rsel), .den(den), .csel(csel), .borderColor(borderColor),
    .backgroundColor(backgroundColor)
  );

  // ------------------------------
  // pixel side
  // ------------------------------
  borderUnit borderUnit_i (
    .clk_dot4x(clk_dot4x), .rst(rst), .dotStrobe(dotStrobe), .rasterX(rasterX),
    .rasterLine(rasterLine), .rsel(rsel), .den(den), .csel(csel), .inBorder(inBorder)
  );

  colorOutput colorOutput_i (
    .clk_dot4x(clk_dot4x), .rst(rst), .chip(chip), .rasterX(rasterX),
    .rasterLine(rasterLine), .inBorder(inBorder), .borderColor(borderColor),
    .backgroundColor(backgroundColor), .colorIndex(colorIndex)
  );

endmodule

// ==== verif/vicVideoTb.sv ====
module vicVideoTb
  import vicPkg::*;
();

  localparam int ClkPeriod = 100;
  // one phi period in clk_dot4x clocks
  localparam int PhiClocks = TicksPerDot * DotsPerPhiCycle;
  // the longest frame of the tested chips, in clocks
  localparam int FrameClocks = TicksPerDot * (int'(rasterXMax[CHIP6569]) + 1)
                             * (int'(rasterYMax[CHIP6569]) + 1);
  // frame waits per test are raster 2, irq 2, border 3 and blanking 3 with one spare
  localparam int TestFrames = 2 + 2 + 3 + 3 + 1;
  localparam longint WatchdogTime = (longint'(TestFrames) * FrameClocks + 10000) * ClkPeriod;

  // one bus cycle of the stimulus table
  typedef struct packed {
    regAddr addr;
    logic [BusWidth-1:0] data;
    logic write;
    logic [BusWidth-1:0] expected;
  } busOp;

  logic clk_dot4x;
  logic rst;
  chipType chip;
  logic ce;
  logic rw;
  logic [BusWidth-1:0] adi;
  logic [BusWidth-1:0] dbi;
  logic [BusWidth-1:0] dbo;
  logic clk_phi;
  logic irq;
  logic [ColorWidth-1:0] colorIndex;

  // index of the next clock since reset went low, as seen at a falling edge
  int clkCount;
  int errorCount;
  int checkCount;
  int testCount;
  int failedTests;
  // register state as written by the testbench
  logic [ColorWidth-1:0] borderVal;
  logic [ColorWidth-1:0] backgroundVal;
  logic rselVal;
  logic denVal;

  vicVideo vicVideo_i (
    .clk_dot4x(clk_dot4x), .rst(rst), .chip(chip), .ce(ce), .rw(rw), .adi(adi),
    .dbi(dbi), .dbo(dbo), .clk_phi(clk_phi), .irq(irq), .colorIndex(colorIndex)
  );

  initial clk_dot4x = 1'b0;
  always #(ClkPeriod / 2) clk_dot4x = ~clk_dot4x;

  always @(posedge clk_dot4x) begin
    if (rst) begin
      clkCount <= 0;
    end else begin
      clkCount <= clkCount + 1;
    end
  end

  initial begin
    #(WatchdogTime);
    $display("watchdog expired before all tests finished");
    $display("Some tests failed");
    $finish;
  end

  // ------------------------------
  // compare tasks
  // ------------------------------
  task checkReg(input string name, input logic [BusWidth-1:0] got,
                input logic [BusWidth-1:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
    end
  endtask

  task checkColor(input string name, input logic [ColorWidth-1:0] got,
                  input logic [ColorWidth-1:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
    end
  endtask

  task checkPin(input string name, input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("MISMATCH time=%0t %s got=%b expected=%b", $time, name, got, exp);
    end
  endtask

  task finishTest(input string name, input int errorsBefore);
    testCount++;
    if (errorCount > errorsBefore) begin
      failedTests++;
      $display("test %s: FAILED with %0d errors", name, errorCount - errorsBefore);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // ------------------------------
  // bus and raster helpers
  // ------------------------------
  task applyReset(input chipType c);
    rst = 1'b1;
    chip = c;
    ce = 1'b1;
    rw = 1'b1;
    adi = '0;
    dbi = '0;
    repeat (3) @(negedge clk_dot4x);
    rst = 1'b0;
    rselVal = 1'b0;
    denVal = 1'b1;
  endtask

  // ce low for one whole phi period, called at a falling edge
  task busAccess(input regAddr addr, input logic [BusWidth-1:0] data, input logic write,
                 output logic [BusWidth-1:0] readData);
    while (clkCount % PhiClocks != 0) @(negedge clk_dot4x);
    // phi is low for the first half of the bus cycle and high for the second
    checkPin("clk_phi", clk_phi, 1'b0);
    ce = 1'b0;
    rw = ~write;
    adi = {6'b0, addr};
    dbi = data;
    repeat (PhiClocks / 2) @(negedge clk_dot4x);
    checkPin("clk_phi", clk_phi, 1'b1);
    repeat (PhiClocks / 2) @(negedge clk_dot4x);
    // last reload was on the final phi high clock
    readData = dbo;
    ce = 1'b1;
    rw = 1'b1;
  endtask

  // stop two clocks into the dot, after colorIndex took this position
  task waitPosition(input int line, input int x);
    int lineDots;
    int target;
    lineDots = int'(rasterXMax[chip]) + 1;
    target = TicksPerDot * (line * lineDots + x) + 2;
    while (target < clkCount) begin
      target += TicksPerDot * lineDots * (int'(rasterYMax[chip]) + 1);
    end
    while (clkCount != target) @(negedge clk_dot4x);
  endtask

  task readLine(input int line);
    logic [BusWidth-1:0] rd;
    logic [RasterLineWidth-1:0] l;
    l = RasterLineWidth'(line);
    busAccess(RegRasterLine, '0, 1'b0, rd);
    checkReg("dbo (0x12)", rd, {4'hF, l[7:0]});
    // bit 8 of the line shares 0x11 with rsel and den
    busAccess(RegControl1, '0, 1'b0, rd);
    checkReg("dbo (0x11)", rd, {4'hF, l[8], 2'b11, denVal, rselVal, 3'b111});
  endtask

  // reads at the start of one line and exactly one line length later
  task lineStep(input int line, input int nextLine);
    int start;
    waitPosition(line, 0);
    while (clkCount % PhiClocks != 0) @(negedge clk_dot4x);
    start = clkCount;
    readLine(line);
    while (clkCount != start + TicksPerDot * (int'(rasterXMax[chip]) + 1)) begin
      @(negedge clk_dot4x);
    end
    readLine(nextLine);
  endtask

  // two nonzero colours that never match
  task pickColors();
    borderVal = ColorWidth'(1 + $urandom % 15);
    backgroundVal = ColorWidth'(1 + (borderVal + $urandom % 14) % 15);
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    busOp ops [8];
    logic [BusWidth-1:0] rd;
    logic [BusWidth-1:0] r16;
    logic [BusWidth-1:0] r1a;
    int mark;
    int line;
    errorCount = 0;
    checkCount = 0;
    testCount = 0;
    failedTests = 0;
    void'($urandom(62919));
    applyReset(CHIP6569);

    // register write and read-back through the table
    mark = errorCount;
    checkReg("dbo after reset", dbo, 12'hFFF);
    pickColors();
    r16 = 12'($urandom);
    r1a = 12'($urandom);
    ops[0] = '{RegBorderColor, {8'($urandom), borderVal}, 1'b1, 12'h000};
    ops[1] = '{RegBackgroundColor, {8'($urandom), backgroundVal}, 1'b1, 12'h000};
    ops[2] = '{RegControl2, r16, 1'b1, 12'h000};
    ops[3] = '{RegIrqEnable, r1a, 1'b1, 12'h000};
    ops[4] = '{RegBorderColor, 12'h000, 1'b0, {8'hFF, borderVal}};
    ops[5] = '{RegBackgroundColor, 12'h000, 1'b0, {8'hFF, backgroundVal}};
    ops[6] = '{RegControl2, 12'h000, 1'b0, {8'hFF, r16[3], 3'b111}};
    ops[7] = '{RegIrqEnable, 12'h000, 1'b0, {11'h7FF, r1a[0]}};
    for (int i = 0; i < 8; i++) begin
      busAccess(ops[i].addr, ops[i].data, ops[i].write, rd);
      if (!ops[i].write) begin
        checkReg($sformatf("dbo (0x%h)", ops[i].addr), rd, ops[i].expected);
      end
    end
    finishTest("register read-back", mark);

    // line count steps by one and wraps after the last line
    mark = errorCount;
    lineStep(100, 101);
    lineStep(int'(rasterYMax[CHIP6569]), 0);
    finishTest("raster counting", mark);

    // compare on line 100, latch pending while disabled
    mark = errorCount;
    busAccess(RegControl1, 12'h018, 1'b1, rd);
    rselVal = 1'b1;
    denVal = 1'b1;
    busAccess(RegRasterLine, 12'd100, 1'b1, rd);
    busAccess(RegIrqEnable, 12'h000, 1'b1, rd);
    busAccess(RegIrqFlags, 12'h001, 1'b1, rd);
    waitPosition(50, 0);
    waitPosition(101, 0);
    busAccess(RegIrqFlags, '0, 1'b0, rd);
    checkReg("dbo (0x19)", rd, 12'hFFF);
    checkPin("irq", irq, 1'b0);
    busAccess(RegIrqEnable, 12'h001, 1'b1, rd);
    @(negedge clk_dot4x);
    checkPin("irq", irq, 1'b1);
    busAccess(RegIrqFlags, '0, 1'b0, rd);
    checkReg("dbo (0x19)", rd, 12'hF7F);
    busAccess(RegIrqFlags, 12'h001, 1'b1, rd);
    // clear pulse lands one clock after the write
    @(negedge clk_dot4x);
    checkPin("irq", irq, 1'b0);
    finishTest("raster interrupt", mark);

    // 25 rows, 40 columns
    mark = errorCount;
    busAccess(RegControl2, 12'h008, 1'b1, rd);
    waitPosition(150, 200);
    checkColor("colorIndex", colorIndex, backgroundVal);
    waitPosition(30, 200);
    checkColor("colorIndex", colorIndex, borderVal);
    waitPosition(150, 350);
    checkColor("colorIndex", colorIndex, borderVal);
    finishTest("border colour", mark);

    mark = errorCount;
    waitPosition(305, 200);
    checkColor("colorIndex", colorIndex, 4'h0);
    applyReset(CHIP6567R56A);
    pickColors();
    busAccess(RegBorderColor, {8'h00, borderVal}, 1'b1, rd);
    busAccess(RegBackgroundColor, {8'h00, backgroundVal}, 1'b1, rd);
    lineStep(int'(rasterYMax[CHIP6567R56A]), 0);
    for (line = 10; line <= 20; line++) begin
      waitPosition(line, 200);
      // lines 11 to 19 blank, the rest show the top border
      checkColor("colorIndex", colorIndex, (line >= 11 && line <= 19) ? 4'h0 : borderVal);
    end
    finishTest("blanking and chip type", mark);

    $display("%0d tests run, %0d failed, %0d checks, %0d errors",
             testCount, failedTests, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
